/* files.f */
matrix_pkg.sv
pixel_writer.sv
framebuffer.sv
matrix_scan.sv
led_matrix_top.sv
tb_led_matrix.sv

/* framebuffer.sv */
// Dual-port pixel RAM
`timescale 1ns/1ps

module framebuffer
	import matrix_pkg::*;
#(
	parameter int COLS = 64,
	parameter int ROWS = 32,
	localparam int AW = $clog2(COLS * ROWS)
) (
	input  logic          clk_root_logic,
	input  logic          wr_en,
	input  logic [AW-1:0] wr_addr,
	input  pixel_word_u   wr_data,
	input  logic [AW-1:0] rd_addr,
	output pixel_word_u   rd_data
);

	// Words in the frame
	localparam int DEPTH = COLS * ROWS;

	// Pixel storage, one word per pixel
	logic [PIXEL_W-1:0] mem [DEPTH];

	// Write port
	// Read port registered, one cycle of latency
	// Same-address collision returns the old word
	always_ff @(posedge clk_root_logic) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

/* led_matrix_top.sv */
// LED matrix display path
`timescale 1ns/1ps

module led_matrix_top
	import matrix_pkg::*;
#(
	parameter int COLS    = 64,
	parameter int ROWS    = 32,
	parameter int OE_BASE = 4,
	localparam int AW = $clog2(COLS * ROWS),
	localparam int RW = $clog2(ROWS / 2)
) (
	input  logic          clk_root_logic,
	input  logic          arst_n,
	input  logic          frame_start,
	input  logic          byte_strobe,
	input  logic [7:0]    byte_data,
	output logic [RW-1:0] row_addr,
	output logic          clk_pixel,
	output logic          row_latch,
	output logic          oe_n,
	output logic [2:0]    rgb_top,
	output logic [2:0]    rgb_bottom
);

	// Write port, writer to RAM
	logic          wr_en;
	logic [AW-1:0] wr_addr;
	pixel_word_u   wr_data;

	// Read port, RAM to scanner
	logic [AW-1:0] rd_addr;
	pixel_word_u   rd_data;

	// Byte stream into the frame
	pixel_writer #(
		.COLS (COLS),
		.ROWS (ROWS)
	) pixel_writer_i (
		.clk_root_logic (clk_root_logic),
		.arst_n         (arst_n),
		.frame_start    (frame_start),
		.byte_strobe    (byte_strobe),
		.byte_data      (byte_data),
		.wr_en          (wr_en),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data)
	);

	// Frame storage
	framebuffer #(
		.COLS (COLS),
		.ROWS (ROWS)
	) framebuffer_i (
		.clk_root_logic (clk_root_logic),
		.wr_en          (wr_en),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.rd_addr        (rd_addr),
		.rd_data        (rd_data)
	);

	// Panel scan
	matrix_scan #(
		.COLS    (COLS),
		.ROWS    (ROWS),
		.OE_BASE (OE_BASE)
	) matrix_scan_i (
		.clk_root_logic (clk_root_logic),
		.arst_n         (arst_n),
		.rd_addr        (rd_addr),
		.rd_data        (rd_data),
		.row_addr       (row_addr),
		.clk_pixel      (clk_pixel),
		.row_latch      (row_latch),
		.oe_n           (oe_n),
		.rgb_top        (rgb_top),
		.rgb_bottom     (rgb_bottom)
	);

endmodule

/* matrix_pkg.sv */
// LED matrix shared definitions
package matrix_pkg;

	// Brightness bit planes per colour channel
	localparam int PLANES = 6;

	// Width of one framebuffer word
	localparam int PIXEL_W = 16;

	// Bytes per pixel on the input stream
	localparam int PIXEL_BYTES = PIXEL_W / 8;

	// One framebuffer word
	// Written as two bytes, high byte first
	// Read back as RGB565 fields
	typedef union packed {
		// Byte view for the writer
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
		// RGB565 view for the scanner
		struct packed {
			// Red, top five bits
			logic [4:0] red;
			// Green, six bits
			logic [5:0] green;
			// Blue, bottom five bits
			logic [4:0] blue;
		} rgb;
	} pixel_word_u;

	// Width of the green field, which sets the widened channel width
	localparam int GREEN_W = 6;

	// Widened channel width matches the plane count
	localparam int CHAN_W = PLANES;

endpackage

/* matrix_scan.sv */
// HUB75 scan with bit-plane modulation
`timescale 1ns/1ps

module matrix_scan
	import matrix_pkg::*;
#(
	parameter int COLS    = 64,
	parameter int ROWS    = 32,
	parameter int OE_BASE = 4,
	localparam int AW = $clog2(COLS * ROWS),
	localparam int RW = $clog2(ROWS / 2)
) (
	input  logic          clk_root_logic,
	input  logic          arst_n,
	output logic [AW-1:0] rd_addr,
	input  pixel_word_u   rd_data,
	output logic [RW-1:0] row_addr,
	output logic          clk_pixel,
	output logic          row_latch,
	output logic          oe_n,
	output logic [2:0]    rgb_top,
	output logic [2:0]    rgb_bottom
);

	// Counter widths
	localparam int CW = $clog2(COLS);
	localparam int PW = $clog2(PLANES);
	// Longest dwell is the top plane
	localparam int TW = $clog2(OE_BASE << (PLANES - 1)) + 1;

	// Wrap points
	localparam logic [CW-1:0] LAST_COL   = CW'(COLS - 1);
	localparam logic [RW-1:0] LAST_PAIR  = RW'(ROWS / 2 - 1);
	localparam logic [PW-1:0] LAST_PLANE = PW'(PLANES - 1);

	// Offset from a top row to its bottom partner
	localparam logic [AW-1:0] HALF_OFFSET = AW'((ROWS / 2) * COLS);

	// FSM encoding
	localparam logic [2:0] ST_FETCH_TOP = 3'd0;
	localparam logic [2:0] ST_FETCH_BOT = 3'd1;
	localparam logic [2:0] ST_PRESENT   = 3'd2;
	localparam logic [2:0] ST_CLOCK     = 3'd3;
	localparam logic [2:0] ST_LATCH     = 3'd4;
	localparam logic [2:0] ST_DISPLAY   = 3'd5;

	logic [2:0]    state;
	logic [CW-1:0] col;
	logic [RW-1:0] pair;
	logic [PW-1:0] plane;
	logic [TW-1:0] timer;

	// Display length of the current plane
	logic [TW-1:0] dwell;

	// Top word held until both halves are in
	pixel_word_u top_word;

	// Pixel addresses for the current column
	logic [AW-1:0] top_addr;
	logic [AW-1:0] bot_addr;

	// Current plane bit of each channel, order blue green red
	function automatic logic [2:0] plane_bits(input pixel_word_u w, input logic [PW-1:0] p);
		logic [CHAN_W-1:0] red6;
		logic [CHAN_W-1:0] green6;
		logic [CHAN_W-1:0] blue6;
		// Five-bit channels repeat their top bit
		red6   = {w.rgb.red, w.rgb.red[4]};
		green6 = w.rgb.green;
		blue6  = {w.rgb.blue, w.rgb.blue[4]};
		return {blue6[p], green6[p], red6[p]};
	endfunction

	assign top_addr = AW'(pair) * AW'(COLS) + AW'(col);
	assign bot_addr = top_addr + HALF_OFFSET;

	// Addresses run one cycle ahead of the data
	// Top word is on the port in the cycle before the top fetch
	assign rd_addr = (state == ST_FETCH_TOP) ? bot_addr : top_addr;

	assign dwell = TW'(OE_BASE) << plane;

	// Catch the top word while the bottom one is requested
	always_ff @(posedge clk_root_logic) begin
		if (state == ST_FETCH_TOP)
			top_word <= rd_data;
	end

	// Scan sequencer with registered panel outputs
	always_ff @(posedge clk_root_logic or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ST_FETCH_TOP;
			col        <= '0;
			pair       <= '0;
			plane      <= '0;
			timer      <= '0;
			row_addr   <= '0;
			clk_pixel  <= 1'b0;
			row_latch  <= 1'b0;
			oe_n       <= 1'b1;
			rgb_top    <= 3'b000;
			rgb_bottom <= 3'b000;
		end else begin
			// Latch strobe is a single cycle
			row_latch <= 1'b0;
			case (state)
				ST_FETCH_TOP: begin
					state <= ST_FETCH_BOT;
				end
				ST_FETCH_BOT: begin
					// Bottom word is on the port now
					rgb_top    <= plane_bits(top_word, plane);
					rgb_bottom <= plane_bits(rd_data, plane);
					state      <= ST_PRESENT;
				end
				ST_PRESENT: begin
					// Panel samples on this rise
					clk_pixel <= 1'b1;
					// Advance early so the next top address goes out now
					if (col == LAST_COL)
						col <= '0;
					else
						col <= col + 1'b1;
					state <= ST_CLOCK;
				end
				ST_CLOCK: begin
					clk_pixel <= 1'b0;
					// Column wrapped, the line is shifted in
					if (col == '0) begin
						row_latch <= 1'b1;
						row_addr  <= pair;
						state     <= ST_LATCH;
					end else begin
						state <= ST_FETCH_TOP;
					end
				end
				ST_LATCH: begin
					// Light the line for the weight of this plane
					oe_n  <= 1'b0;
					timer <= dwell - 1'b1;
					// Move to the next line during display
					if (plane == LAST_PLANE) begin
						plane <= '0;
						if (pair == LAST_PAIR)
							pair <= '0;
						else
							pair <= pair + 1'b1;
					end else begin
						plane <= plane + 1'b1;
					end
					state <= ST_DISPLAY;
				end
				ST_DISPLAY: begin
					if (timer == '0) begin
						oe_n  <= 1'b1;
						state <= ST_FETCH_TOP;
					end else begin
						timer <= timer - 1'b1;
					end
				end
				default: begin
					// Unused codes restart the column
					state     <= ST_FETCH_TOP;
					clk_pixel <= 1'b0;
					oe_n      <= 1'b1;
				end
			endcase
		end
	end

endmodule

/* pixel_writer.sv */
// Byte stream to pixel writer
`timescale 1ns/1ps

module pixel_writer
	import matrix_pkg::*;
#(
	parameter int COLS = 64,
	parameter int ROWS = 32,
	localparam int AW = $clog2(COLS * ROWS)
) (
	input  logic          clk_root_logic,
	input  logic          arst_n,
	input  logic          frame_start,
	input  logic          byte_strobe,
	input  logic [7:0]    byte_data,
	output logic          wr_en,
	output logic [AW-1:0] wr_addr,
	output pixel_word_u   wr_data
);

	// Last address of the frame
	localparam logic [AW-1:0] LAST_ADDR = AW'(COLS * ROWS - 1);

	// Low when the next byte is the high byte
	logic phase;

	// Byte accepted this cycle, frame_start drops it
	logic take_byte;

	assign take_byte = byte_strobe & ~frame_start;

	// Control path
	always_ff @(posedge clk_root_logic or negedge arst_n) begin
		if (!arst_n) begin
			phase   <= 1'b0;
			wr_en   <= 1'b0;
			wr_addr <= '0;
		end else begin
			// Write strobe lasts a single cycle
			wr_en <= 1'b0;
			if (frame_start) begin
				// Rewind to the first pixel
				phase   <= 1'b0;
				wr_addr <= '0;
			end else begin
				// Step past the word written on this edge
				if (wr_en) begin
					if (wr_addr == LAST_ADDR)
						wr_addr <= '0;
					else
						wr_addr <= wr_addr + 1'b1;
				end
				if (take_byte) begin
					phase <= ~phase;
					// Second byte completes the pixel
					if (phase)
						wr_en <= 1'b1;
				end
			end
		end
	end

	// Pixel assembly, high byte first
	// The pending write reads the word before a new high byte lands
	always_ff @(posedge clk_root_logic) begin
		if (take_byte) begin
			if (!phase)
				wr_data.bytes.hi <= byte_data;
			else
				wr_data.bytes.lo <= byte_data;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the LED matrix testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_led_matrix -f files.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0

/* tb_led_matrix.sv */
// LED matrix display testbench
`timescale 1ns/1ps

module tb_led_matrix
	import matrix_pkg::*;
;

	localparam int COLS    = 8;
	localparam int ROWS    = 4;
	localparam int OE_BASE = 2;
	localparam int NPIX    = COLS * ROWS;
	localparam int PAIRS   = ROWS / 2;
	localparam int RW      = $clog2(PAIRS);
	// Lines in one full scan of the panel
	localparam int LINES   = PLANES * PAIRS;
	// Cycle budget for any single wait
	localparam int TIMEOUT = 4 * COLS + (OE_BASE << PLANES) + 64;

	logic          clk_root_logic;
	logic          arst_n;
	logic          frame_start;
	logic          byte_strobe;
	logic [7:0]    byte_data;
	logic [RW-1:0] row_addr;
	logic          clk_pixel;
	logic          row_latch;
	logic          oe_n;
	logic [2:0]    rgb_top;
	logic [2:0]    rgb_bottom;

	// Reference frame as the DUT should hold it
	pixel_word_u model [NPIX];
	int          wptr;
	logic        phase;
	logic [7:0]  hold_hi;

	logic [31:0] rng;
	int          err_count;
	int          timeout_count;

	// Scan position for error lines
	int cur_pair;
	int cur_plane;
	int cur_col;

	led_matrix_top #(
		.COLS    (COLS),
		.ROWS    (ROWS),
		.OE_BASE (OE_BASE)
	) led_matrix_top_i (
		.clk_root_logic (clk_root_logic),
		.arst_n         (arst_n),
		.frame_start    (frame_start),
		.byte_strobe    (byte_strobe),
		.byte_data      (byte_data),
		.row_addr       (row_addr),
		.clk_pixel      (clk_pixel),
		.row_latch      (row_latch),
		.oe_n           (oe_n),
		.rgb_top        (rgb_top),
		.rgb_bottom     (rgb_bottom)
	);

	initial begin
		clk_root_logic = 1'b0;
		forever #5 clk_root_logic = ~clk_root_logic;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Plane bit of each channel in blue green red order
	// Five-bit channels gain their msb as a new lsb
	// Plane 0 therefore shows the msb
	function automatic logic [2:0] expected_bits(input pixel_word_u w, input int p);
		logic r;
		logic g;
		logic b;
		g = w.rgb.green[p];
		if (p == 0) begin
			r = w.rgb.red[4];
			b = w.rgb.blue[4];
		end else begin
			r = w.rgb.red[p-1];
			b = w.rgb.blue[p-1];
		end
		return {b, g, r};
	endfunction

	task automatic check_rgb(input string name, input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("ERR %s: got 0x%h expected 0x%h at pair %0d plane %0d col %0d",
				name, got, exp, cur_pair, cur_plane, cur_col);
		end
	endtask

	task automatic check_row(input logic [RW-1:0] got, input logic [RW-1:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("ERR row_addr: got 0x%h expected 0x%h at plane %0d", got, exp, cur_plane);
		end
	endtask

	task automatic check_oe_len(input int got, input int exp);
		if (got != exp) begin
			err_count++;
			$display("ERR oe_n low cycles: got 0x%h expected 0x%h at pair %0d plane %0d",
				got, exp, cur_pair, cur_plane);
		end
	endtask

	// Pixel clocks shifted in before a latch
	task automatic check_cols(input int got, input int exp);
		if (got != exp) begin
			err_count++;
			$display("ERR clk_pixel rises per line: got 0x%h expected 0x%h at pair %0d plane %0d",
				got, exp, cur_pair, cur_plane);
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			err_count++;
			$display("ERR %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic idle_cycle();
		@(negedge clk_root_logic);
		byte_strobe = 1'b0;
		frame_start = 1'b0;
	endtask

	// One byte after a random gap
	// Model mirrors each completed pixel
	task automatic send_byte(input logic [7:0] b);
		rng = xorshift32(rng);
		repeat (rng[1:0]) idle_cycle();
		@(negedge clk_root_logic);
		byte_strobe = 1'b1;
		frame_start = 1'b0;
		byte_data   = b;
		if (!phase) begin
			hold_hi = b;
		end else begin
			model[wptr].bytes.hi = hold_hi;
			model[wptr].bytes.lo = b;
			wptr = (wptr + 1) % NPIX;
		end
		phase = ~phase;
	endtask

	task automatic send_pixel(input pixel_word_u w);
		send_byte(w.bytes.hi);
		send_byte(w.bytes.lo);
	endtask

	// Frame start with an optional colliding byte that must be dropped
	task automatic rewind(input logic with_byte);
		rng = xorshift32(rng);
		@(negedge clk_root_logic);
		frame_start = 1'b1;
		byte_strobe = with_byte;
		byte_data   = rng[7:0];
		wptr  = 0;
		phase = 1'b0;
		idle_cycle();
	endtask

	task automatic write_frame(input logic fill, input pixel_word_u value);
		pixel_word_u w;
		for (int i = 0; i < NPIX; i++) begin
			rng = xorshift32(rng);
			w = fill ? value : pixel_word_u'(rng[23:8]);
			send_pixel(w);
		end
		// Let the last write land
		repeat (4) idle_cycle();
	endtask

	task automatic wait_pixel_rise(output logic ok);
		int t;
		t  = 0;
		ok = 1'b0;
		while (!ok && t < TIMEOUT) begin
			@(negedge clk_root_logic);
			t++;
			if (clk_pixel === 1'b1)
				ok = 1'b1;
		end
		if (!ok) begin
			timeout_count++;
			$display("Timed out waiting for clk_pixel to rise");
		end
	endtask

	// Pixel clocks seen on the way to the latch are counted
	task automatic wait_latch(output logic ok, output int rises);
		int t;
		t     = 0;
		ok    = 1'b0;
		rises = 0;
		while (!ok && t < TIMEOUT) begin
			@(negedge clk_root_logic);
			t++;
			if (row_latch === 1'b1)
				ok = 1'b1;
			else if (clk_pixel === 1'b1)
				rises++;
		end
		if (!ok) begin
			timeout_count++;
			$display("Timed out waiting for row_latch");
		end
	endtask

	// Length of the oe_n low window after a latch
	task automatic measure_oe(output int len);
		int t;
		t   = 0;
		len = 0;
		while (oe_n !== 1'b0 && t < TIMEOUT) begin
			@(negedge clk_root_logic);
			t++;
		end
		if (oe_n !== 1'b0) begin
			timeout_count++;
			$display("Timed out waiting for oe_n to go low after a latch");
		end
		while (oe_n === 1'b0 && len < TIMEOUT) begin
			len++;
			@(negedge clk_root_logic);
		end
		if (len >= TIMEOUT) begin
			timeout_count++;
			$display("oe_n stayed low past the longest display time");
		end
	endtask

	// Follow one full scan from the end of pair 0 plane 0 back to it
	task automatic check_scan();
		logic ok;
		logic aligned;
		int   prev_row;
		int   seen;
		int   len;
		int   top_a;
		int   rises;
		ok       = 1'b1;
		aligned  = 1'b0;
		prev_row = 0;
		seen     = 0;
		// First pair 0 latch right after the last pair
		while (ok && !aligned && seen < 3 * LINES) begin
			wait_latch(ok, rises);
			seen++;
			if (ok) begin
				if (row_addr == '0 && prev_row != 0)
					aligned = 1'b1;
				prev_row = int'(row_addr);
			end
		end
		if (ok && !aligned) begin
			timeout_count++;
			$display("Never saw the scan return to row pair 0");
			ok = 1'b0;
		end
		if (ok) begin
			cur_pair  = 0;
			cur_plane = 0;
			measure_oe(len);
			check_oe_len(len, OE_BASE);
		end
		for (int line = 1; ok && line <= LINES; line++) begin
			cur_plane = line % PLANES;
			cur_pair  = (line / PLANES) % PAIRS;
			for (int col = 0; ok && col < COLS; col++) begin
				cur_col = col;
				wait_pixel_rise(ok);
				if (ok) begin
					top_a = cur_pair * COLS + col;
					check_rgb("rgb_top", rgb_top, expected_bits(model[top_a], cur_plane));
					check_rgb("rgb_bottom", rgb_bottom,
						expected_bits(model[top_a + PAIRS * COLS], cur_plane));
				end
			end
			if (ok)
				wait_latch(ok, rises);
			if (ok) begin
				// No extra column may slip in before the latch
				check_cols(COLS + rises, COLS);
				check_row(row_addr, RW'(cur_pair));
				measure_oe(len);
				check_oe_len(len, OE_BASE << cur_plane);
			end
		end
	endtask

	initial begin
		int n_partial;
		rng           = 32'h30f7_282a;
		err_count     = 0;
		timeout_count = 0;
		cur_pair      = 0;
		cur_plane     = 0;
		cur_col       = 0;
		arst_n        = 1'b0;
		frame_start   = 1'b0;
		byte_strobe   = 1'b0;
		byte_data     = 8'h00;
		wptr          = 0;
		phase         = 1'b0;
		hold_hi       = 8'h00;
		for (int i = 0; i < NPIX; i++)
			model[i] = '0;

		repeat (2) @(negedge clk_root_logic);
		arst_n = 1'b1;
		// Outputs still hold their reset levels here
		check_level("oe_n", oe_n, 1'b1);
		check_level("clk_pixel", clk_pixel, 1'b0);
		check_level("row_latch", row_latch, 1'b0);
		check_rgb("rgb_top", rgb_top, 3'b000);
		check_rgb("rgb_bottom", rgb_bottom, 3'b000);
		check_row(row_addr, '0);

		// Random frame over every column, plane and pair
		rewind(1'b0);
		write_frame(1'b0, '0);
		check_scan();

		// Partial frame and an odd byte before a rewind that eats a byte
		rng = xorshift32(rng);
		n_partial = 3 + int'(rng[2:0]);
		for (int i = 0; i < n_partial; i++)
			send_pixel(pixel_word_u'(rng[31:16] ^ 16'(i)));
		send_byte(8'hc3);
		rewind(1'b1);
		write_frame(1'b0, '0);
		check_scan();

		// Edge values for the widening rule
		rewind(1'b0);
		write_frame(1'b1, 16'h0000);
		check_scan();
		rewind(1'b0);
		write_frame(1'b1, 16'hffff);
		check_scan();
		// Red and blue msb only
		rewind(1'b0);
		write_frame(1'b1, 16'h8010);
		check_scan();

		$display("Checks done: %0d value errors, %0d timeouts", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
